// ==== Makefile ====
# Verilator flow for the host to DRAM bridge
VERILATOR ?= verilator
TOP       ?= tb_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
verilog/bridge_pkg.sv
verilog/host_port.sv
verilog/dram_sequencer.sv
verilog/reply_buffer.sv
verilog/host_dram_bridge.sv
tb/tb_clock.sv
tb/dram_model.sv
tb/tb_bridge.sv

// ==== tb/dram_model.sv ====
module dram_model #(
  parameter int ADDR_WIDTH = 27
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              app_en,
  input  logic                              app_cmd,
  input  logic [ADDR_WIDTH-1:0]             app_addr,
  output logic                              app_rdy,
  input  logic                              app_wdf_wren,
  input  logic                              app_wdf_end,
  input  logic [bridge_pkg::BEAT_WIDTH-1:0] app_wdf_data,
  output logic                              app_wdf_rdy,
  output logic                              app_rd_data_valid,
  output logic [bridge_pkg::BEAT_WIDTH-1:0] app_rd_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import bridge_pkg::*;

  localparam logic [31:0] SEED = 32'h71f1;

  logic [BEAT_WIDTH-1:0]      mem [logic [BEAT_ADDR_WIDTH-1:0]];
  logic [BEAT_ADDR_WIDTH-1:0] waddr_q [$];
  logic [BEAT_WIDTH-1:0]      wdata_q [$];
  // Read beats waiting to return, with the cycle each is due
  logic [BEAT_WIDTH-1:0]      rdata_q [$];
  int                         rdue_q [$];
  logic [31:0]                lfsr;
  int                         cycle;
  int                         last_due;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [3:0] rand_bits(input int n);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  // Unwritten beats hold a pattern of their own address
  function automatic logic [BEAT_WIDTH-1:0] read_beat(
    input logic [BEAT_ADDR_WIDTH-1:0] beat
  );
    logic [BEAT_WIDTH-1:0] b;
    if (mem.exists(beat)) begin
      return mem[beat];
    end
    for (int w = 0; w < WORDS_PER_BEAT; w++) begin
      b[w*MSG_WIDTH +: MSG_WIDTH] = {4'ha, 4'(w), beat};
    end
    return b;
  endfunction

  initial begin
    logic [BEAT_ADDR_WIDTH-1:0] beat;
    logic [3:0]                 bits;
    int                         due;
    app_rdy           = 1'b0;
    app_wdf_rdy       = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data       = '0;
    lfsr              = SEED;
    cycle             = 0;
    last_due          = 0;
    forever begin
      @(posedge clk);
      cycle++;
      beat = BEAT_ADDR_WIDTH'(app_addr >> 3);
      if (arst_n) begin
        if (app_en && app_rdy && !app_cmd) begin
          waddr_q.push_back(beat);
        end
        // Only a beat that ends its burst is stored
        if (app_wdf_wren && app_wdf_rdy && app_wdf_end) begin
          wdata_q.push_back(app_wdf_data);
        end
        // Write commands and data beats pair in order
        while (waddr_q.size() != 0 && wdata_q.size() != 0) begin
          mem[waddr_q.pop_front()] = wdata_q.pop_front();
        end
        if (app_en && app_rdy && app_cmd) begin
          due = cycle + 2 + int'(rand_bits(3));
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rdata_q.push_back(read_beat(beat));
          rdue_q.push_back(due);
        end
      end
      #1;
      if (!arst_n) begin
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data_valid = 1'b0;
      end else begin
        bits        = rand_bits(2);
        app_rdy     = (bits != '0);
        bits        = rand_bits(2);
        app_wdf_rdy = (bits != '0);
        if (rdue_q.size() != 0 && rdue_q[0] <= cycle) begin
          app_rd_data_valid = 1'b1;
          app_rd_data       = rdata_q.pop_front();
          void'(rdue_q.pop_front());
        end else begin
          app_rd_data_valid = 1'b0;
        end
      end
    end
  end

endmodule

// ==== tb/tb_bridge.sv ====
module tb_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import bridge_pkg::*;

  localparam int ADDR_WIDTH  = 27;
  localparam int REPLY_DEPTH = 4;
  // Cycles allowed per Wishbone word
  localparam int WORD_BOUND  = 40;
  // Wishbone words of the whole run, test by test
  localparam int TOTAL_WORDS = 1 + 2 * 25 + 17 + (17 + 3 + 56) + 49 + 23 + 13;

  logic                  clk;
  logic                  arst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic                  wb_adr;
  logic [MSG_WIDTH-1:0]  wb_dat_i;
  logic [MSG_WIDTH-1:0]  wb_dat_o;
  logic                  wb_ack;
  logic                  app_en;
  logic                  app_cmd;
  logic [ADDR_WIDTH-1:0] app_addr;
  logic                  app_rdy;
  logic                  app_wdf_wren;
  logic                  app_wdf_end;
  logic [BEAT_WIDTH-1:0] app_wdf_data;
  logic                  app_wdf_rdy;
  logic                  app_rd_data_valid;
  logic [BEAT_WIDTH-1:0] app_rd_data;
  logic                  error;
  logic                  done;

  logic [BEAT_WIDTH-1:0] shadow [logic [BEAT_ADDR_WIDTH-1:0]];
  msg_word_t             exp_q [$];
  msg_word_t             got_q [$];
  int                    word_errors  = 0;
  int                    flag_errors  = 0;
  int                    count_errors = 0;
  int                    cmd_xfers    = 0;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clock (.*);

  host_dram_bridge #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .REPLY_DEPTH (REPLY_DEPTH)
  ) DUT (.*);

  dram_model #(.ADDR_WIDTH(ADDR_WIDTH)) u_dram (.*);

  // ********************
  // Reference model
  // ********************
  function automatic msg_word_t command_word(input logic [OP_WIDTH-1:0] op, input int len,
                                             input logic [BEAT_ADDR_WIDTH-1:0] addr);
    msg_word_t w;
    w.cmd.opcode    = op;
    w.cmd.length    = LEN_WIDTH'(len);
    w.cmd.beat_addr = addr;
    return w;
  endfunction

  function automatic msg_word_t payload_word(input logic [7:0] tag,
                                             input logic [BEAT_ADDR_WIDTH-1:0] beat, input int idx);
    msg_word_t w;
    w.raw = {tag, beat[15:0], 5'd0, 3'(idx)};
    return w;
  endfunction

  function automatic msg_word_t expected_word(input logic [BEAT_ADDR_WIDTH-1:0] beat,
                                              input int idx);
    msg_word_t w;
    if (shadow.exists(beat)) begin
      w.raw = shadow[beat][idx*MSG_WIDTH +: MSG_WIDTH];
    end else begin
      // Never written, address pattern of the memory
      w.raw = {4'ha, 4'(idx), beat};
    end
    return w;
  endfunction

  // ********************
  // Checks
  // ********************
  task automatic check_word(input msg_word_t got, input msg_word_t exp);
    if (got.raw !== exp.raw) begin
      word_errors++;
      $display("error at %0t: reply word %h, expected %h", $time, got.raw, exp.raw);
    end
  endtask

  task automatic check_flags(input logic got_error, input logic got_done,
                             input logic exp_error, input logic exp_done);
    if (got_error !== exp_error || got_done !== exp_done) begin
      flag_errors++;
      $display("error at %0t: status error=%b done=%b, expected error=%b done=%b",
               $time, got_error, got_done, exp_error, exp_done);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      count_errors++;
      $display("error at %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ********************
  // Wishbone host
  // ********************
  task automatic bus_cycle(input logic we, input logic adr, input logic [MSG_WIDTH-1:0] data,
                           output logic [MSG_WIDTH-1:0] rdata);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = data;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
    rdata  = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic send_word(input msg_word_t w);
    logic [MSG_WIDTH-1:0] unused;
    bus_cycle(1'b1, 1'b0, w.raw, unused);
  endtask

  task automatic expect_status(input logic exp_error, input logic exp_done);
    logic [MSG_WIDTH-1:0] d;
    bus_cycle(1'b0, 1'b1, '0, d);
    check_flags(d[0], d[1], exp_error, exp_done);
    // Flag outputs of the bridge
    check_flags(error, done, exp_error, exp_done);
  endtask

  // Shadow memory follows only the writes that should land
  task automatic write_burst(input logic [BEAT_ADDR_WIDTH-1:0] addr, input int len,
                             input logic [7:0] tag, input bit live);
    logic [BEAT_WIDTH-1:0]      beat_data;
    logic [BEAT_ADDR_WIDTH-1:0] beat;
    msg_word_t                  w;
    send_word(command_word(OP_WRITE, len, addr));
    for (int b = 0; b < len; b++) begin
      beat = addr + BEAT_ADDR_WIDTH'(b);
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        w = payload_word(tag, beat, i);
        beat_data[i*MSG_WIDTH +: MSG_WIDTH] = w.raw;
        send_word(w);
      end
      if (live) begin
        shadow[beat] = beat_data;
      end
    end
  endtask

  task automatic read_cmd(input logic [BEAT_ADDR_WIDTH-1:0] addr, input int len, input bit live);
    send_word(command_word(OP_READ, len, addr));
    if (live) begin
      for (int b = 0; b < len; b++) begin
        for (int i = 0; i < WORDS_PER_BEAT; i++) begin
          exp_q.push_back(expected_word(addr + BEAT_ADDR_WIDTH'(b), i));
        end
      end
    end
  endtask

  // Pause, when given, comes before each beat's first word
  task automatic drain(input int words, input int pause);
    logic [MSG_WIDTH-1:0] d;
    msg_word_t            w;
    for (int k = 0; k < words; k++) begin
      if (pause > 0 && k % WORDS_PER_BEAT == 0) begin
        repeat (pause) @(posedge clk);
      end
      bus_cycle(1'b0, 1'b0, '0, d);
      w.raw = d;
      got_q.push_back(w);
    end
  endtask

  // Reply compare
  always @(posedge clk) begin
    msg_word_t got;
    while (got_q.size() != 0) begin
      got = got_q.pop_front();
      if (exp_q.size() == 0) begin
        word_errors++;
        $display("Reply word %h arrived with nothing expected", got.raw);
      end else begin
        check_word(got, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && app_en && app_rdy) begin
      cmd_xfers++;
    end
  end

  initial begin
    repeat (TOTAL_WORDS * WORD_BOUND) @(posedge clk);
    $display("Timeout: run still busy after %0d cycles", TOTAL_WORDS * WORD_BOUND);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int xfers_before;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 1'b0;
    wb_dat_i = '0;
    @(posedge arst_n);
    expect_status(1'b0, 1'b0);

    write_burst(24'h000100, 3, 8'h11, 1'b1);
    read_cmd(24'h000100, 3, 1'b1);
    drain(24, 0);

    // Beats nobody wrote
    read_cmd(24'h0a5000, 2, 1'b1);
    drain(16, 0);

    // Three reads queued before any reply is taken
    write_burst(24'h000200, 2, 8'h22, 1'b1);
    read_cmd(24'h000200, 2, 1'b1);
    read_cmd(24'h0000ff, 2, 1'b1);
    read_cmd(24'h000101, 3, 1'b1);
    drain(56, 0);

    // Slow host, more beats than the reply FIFO holds
    read_cmd(24'h0000fe, 6, 1'b1);
    drain(48, REPLY_DEPTH * WORDS_PER_BEAT * 2);

    // Bad opcode and empty bursts
    send_word(command_word(2'd0, 1, 24'h000400));
    send_word(command_word(OP_WRITE, 0, 24'h000400));
    send_word(command_word(OP_READ, 0, 24'h000400));
    expect_status(1'b1, 1'b0);
    write_burst(24'h000300, 1, 8'h33, 1'b1);
    read_cmd(24'h000300, 1, 1'b1);
    drain(8, 0);
    expect_status(1'b1, 1'b0);

    // Session end, later words must not reach the memory
    xfers_before = cmd_xfers;
    send_word(command_word(OP_END, 1, 24'h000000));
    expect_status(1'b1, 1'b1);
    write_burst(24'h000300, 1, 8'h44, 1'b0);
    read_cmd(24'h000300, 1, 1'b0);
    expect_status(1'b1, 1'b1);
    repeat (20) @(posedge clk);
    check_count(cmd_xfers, xfers_before, "DRAM command");

    repeat (2) @(posedge clk);
    if (exp_q.size() != 0) begin
      word_errors++;
      $display("%0d expected reply words never arrived", exp_q.size());
    end
    $display("Errors: %0d word, %0d flag, %0d count", word_errors, flag_errors, count_errors);
    if (word_errors + flag_errors + count_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release just after a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

// ==== verilog/bridge_pkg.sv ====
package bridge_pkg;

  // ********************
  // Message and beat sizes
  // ********************

  // One host message word
  localparam int MSG_WIDTH       = 32;
  // Message words packed into one DRAM beat
  localparam int WORDS_PER_BEAT  = 8;
  localparam int BEAT_WIDTH      = MSG_WIDTH * WORDS_PER_BEAT;

  // Command word fields, 2 + 6 + 24 bits fill one message word
  localparam int OP_WIDTH        = 2;
  localparam int LEN_WIDTH       = 6;
  localparam int BEAT_ADDR_WIDTH = 24;

  // ********************
  // Opcodes
  // ********************

  // Opcode 0 is reserved as invalid
  localparam logic [OP_WIDTH-1:0] OP_WRITE = 2'd1;
  localparam logic [OP_WIDTH-1:0] OP_READ  = 2'd2;
  localparam logic [OP_WIDTH-1:0] OP_END   = 2'd3;

  // One message word, seen as a command or as raw payload
  typedef union packed {
    struct packed {
      logic [OP_WIDTH-1:0]        opcode;
      // Number of beats to write or read
      logic [LEN_WIDTH-1:0]       length;
      // First beat of the burst
      logic [BEAT_ADDR_WIDTH-1:0] beat_addr;
    } cmd;
    logic [MSG_WIDTH-1:0] raw;
  } msg_word_t;

endpackage

// ==== verilog/dram_sequencer.sv ====
module dram_sequencer #(
  parameter int ADDR_WIDTH = 27
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   wr_valid,
  input  logic [bridge_pkg::BEAT_ADDR_WIDTH-1:0] wr_addr,
  input  logic [bridge_pkg::BEAT_WIDTH-1:0]      wr_data,
  output logic                                   wr_ready,
  input  logic                                   rd_valid,
  input  logic [bridge_pkg::BEAT_ADDR_WIDTH-1:0] rd_addr,
  input  logic [bridge_pkg::LEN_WIDTH-1:0]       rd_len,
  output logic                                   rd_ready,
  input  logic                                   slot_free,
  output logic                                   read_issued,
  output logic                                   app_en,
  output logic                                   app_cmd,
  output logic [ADDR_WIDTH-1:0]                  app_addr,
  input  logic                                   app_rdy,
  output logic                                   app_wdf_wren,
  output logic                                   app_wdf_end,
  output logic [bridge_pkg::BEAT_WIDTH-1:0]      app_wdf_data,
  input  logic                                   app_wdf_rdy
);
  import bridge_pkg::*;

  // Column address steps by 8 per 256-bit beat
  localparam int BEAT_SHIFT = 3;

  logic                       cmd_pend;
  logic [BEAT_ADDR_WIDTH-1:0] cmd_beat;
  logic [LEN_WIDTH-1:0]       rd_left;
  logic                       reading;
  logic                       idle;
  logic                       cmd_xfer;
  logic                       wr_take;
  logic                       rd_take;

  assign reading = (rd_left != '0);

  // Next request only once both write sides and all reads are done
  assign idle     = !cmd_pend && !app_wdf_wren && !reading;
  assign wr_ready = idle;
  assign rd_ready = idle && !wr_valid;
  assign wr_take  = wr_valid && wr_ready;
  assign rd_take  = rd_valid && rd_ready;

  // ********************
  // Command channel
  // ********************

  // Reads go out only while the reply FIFO has a free slot
  assign app_en      = cmd_pend || (reading && slot_free);
  assign app_cmd     = reading;
  assign app_addr    = ADDR_WIDTH'({cmd_beat, {BEAT_SHIFT{1'b0}}});
  assign cmd_xfer    = app_en && app_rdy;
  assign read_issued = cmd_xfer && app_cmd;

  // Single beat bursts
  assign app_wdf_end = app_wdf_wren;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_pend     <= 1'b0;
      app_wdf_wren <= 1'b0;
      rd_left      <= '0;
    end else begin
      if (wr_take) begin
        cmd_pend     <= 1'b1;
        app_wdf_wren <= 1'b1;
      end else begin
        // Command and data retire independently
        if (cmd_xfer && !app_cmd) begin
          cmd_pend <= 1'b0;
        end
        if (app_wdf_wren && app_wdf_rdy) begin
          app_wdf_wren <= 1'b0;
        end
      end
      if (rd_take) begin
        rd_left <= rd_len;
      end else if (read_issued) begin
        rd_left <= rd_left - 1'b1;
      end
    end
  end

  // Beat address and write payload
  always_ff @(posedge clk) begin
    if (wr_take) begin
      cmd_beat     <= wr_addr;
      app_wdf_data <= wr_data;
    end else if (rd_take) begin
      cmd_beat <= rd_addr;
    end else if (read_issued) begin
      cmd_beat <= cmd_beat + 1'b1;
    end
  end

  app_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
    app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd));

  read_has_slot: assert property (@(posedge clk) disable iff (!arst_n)
    read_issued |-> slot_free);

endmodule

// ==== verilog/host_dram_bridge.sv ====
module host_dram_bridge #(
  parameter int ADDR_WIDTH  = 27,
  parameter int REPLY_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic                              wb_adr,
  input  logic [bridge_pkg::MSG_WIDTH-1:0]  wb_dat_i,
  output logic [bridge_pkg::MSG_WIDTH-1:0]  wb_dat_o,
  output logic                              wb_ack,
  output logic                              app_en,
  output logic                              app_cmd,
  output logic [ADDR_WIDTH-1:0]             app_addr,
  input  logic                              app_rdy,
  output logic                              app_wdf_wren,
  output logic                              app_wdf_end,
  output logic [bridge_pkg::BEAT_WIDTH-1:0] app_wdf_data,
  input  logic                              app_wdf_rdy,
  input  logic                              app_rd_data_valid,
  input  logic [bridge_pkg::BEAT_WIDTH-1:0] app_rd_data,
  output logic                              error,
  output logic                              done
);
  import bridge_pkg::*;

  // ********************
  // Internal handshakes
  // ********************
  logic                       wr_valid;
  logic [BEAT_ADDR_WIDTH-1:0] wr_addr;
  logic [BEAT_WIDTH-1:0]      wr_data;
  logic                       wr_ready;
  logic                       rd_valid;
  logic [BEAT_ADDR_WIDTH-1:0] rd_addr;
  logic [LEN_WIDTH-1:0]       rd_len;
  logic                       rd_ready;
  logic                       slot_free;
  logic                       read_issued;
  logic                       reply_valid;
  logic [MSG_WIDTH-1:0]       reply_word;
  logic                       reply_take;

  host_port u_host_port (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .wr_valid    (wr_valid),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_ready    (wr_ready),
    .rd_valid    (rd_valid),
    .rd_addr     (rd_addr),
    .rd_len      (rd_len),
    .rd_ready    (rd_ready),
    .reply_valid (reply_valid),
    .reply_word  (reply_word),
    .reply_take  (reply_take),
    .error       (error),
    .done        (done)
  );

  dram_sequencer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_dram_sequencer (
    .clk          (clk),
    .arst_n       (arst_n),
    .wr_valid     (wr_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_ready     (wr_ready),
    .rd_valid     (rd_valid),
    .rd_addr      (rd_addr),
    .rd_len       (rd_len),
    .rd_ready     (rd_ready),
    .slot_free    (slot_free),
    .read_issued  (read_issued),
    .app_en       (app_en),
    .app_cmd      (app_cmd),
    .app_addr     (app_addr),
    .app_rdy      (app_rdy),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_wdf_data (app_wdf_data),
    .app_wdf_rdy  (app_wdf_rdy)
  );

  reply_buffer #(
    .REPLY_DEPTH (REPLY_DEPTH)
  ) u_reply_buffer (
    .clk               (clk),
    .arst_n            (arst_n),
    .read_issued       (read_issued),
    .slot_free         (slot_free),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data),
    .reply_valid       (reply_valid),
    .reply_word        (reply_word),
    .reply_take        (reply_take)
  );

endmodule

// ==== verilog/host_port.sv ====
module host_port (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic                                   wb_adr,
  input  logic [bridge_pkg::MSG_WIDTH-1:0]       wb_dat_i,
  output logic [bridge_pkg::MSG_WIDTH-1:0]       wb_dat_o,
  output logic                                   wb_ack,
  output logic                                   wr_valid,
  output logic [bridge_pkg::BEAT_ADDR_WIDTH-1:0] wr_addr,
  output logic [bridge_pkg::BEAT_WIDTH-1:0]      wr_data,
  input  logic                                   wr_ready,
  output logic                                   rd_valid,
  output logic [bridge_pkg::BEAT_ADDR_WIDTH-1:0] rd_addr,
  output logic [bridge_pkg::LEN_WIDTH-1:0]       rd_len,
  input  logic                                   rd_ready,
  input  logic                                   reply_valid,
  input  logic [bridge_pkg::MSG_WIDTH-1:0]       reply_word,
  output logic                                   reply_take,
  output logic                                   error,
  output logic                                   done
);
  import bridge_pkg::*;

  localparam int IDX_WIDTH = $clog2(WORDS_PER_BEAT);

  localparam logic [1:0] ST_CMD  = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0]           state;
  logic [LEN_WIDTH-1:0] beats_left;
  logic [IDX_WIDTH-1:0] word_idx;
  msg_word_t            msg;
  logic                 req;
  logic                 decode;
  logic                 msg_wr;
  logic                 cmd_load;
  logic                 load_word;
  logic                 last_word;
  logic                 cmd_ok;
  logic [MSG_WIDTH-1:0] status_word;

  assign msg = wb_dat_i;

  // A new bus request; nothing is decoded while a beat or read is pending
  assign req       = wb_cyc && wb_stb && !wb_ack;
  assign decode    = req && !wr_valid && !rd_valid;
  assign msg_wr    = decode && wb_we && !wb_adr;
  assign cmd_load  = msg_wr && (state == ST_CMD);
  assign load_word = msg_wr && (state == ST_DATA);

  assign last_word   = (word_idx == IDX_WIDTH'(WORDS_PER_BEAT - 1));
  assign cmd_ok      = (msg.cmd.length != '0);
  assign status_word = {{(MSG_WIDTH - 2){1'b0}}, done, error};
  assign reply_take  = decode && !wb_we && !wb_adr && reply_valid;

  // ********************
  // Message FSM
  // ********************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_CMD;
      beats_left <= '0;
      word_idx   <= '0;
      wb_ack     <= 1'b0;
      wr_valid   <= 1'b0;
      rd_valid   <= 1'b0;
      error      <= 1'b0;
      done       <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      if (wr_valid && wr_ready) begin
        // Beat handed over, finish the held 8th word
        wr_valid   <= 1'b0;
        wb_ack     <= 1'b1;
        word_idx   <= '0;
        beats_left <= beats_left - 1'b1;
        if (beats_left == LEN_WIDTH'(1)) begin
          state <= ST_CMD;
        end
      end else if (rd_valid && rd_ready) begin
        rd_valid <= 1'b0;
        wb_ack   <= 1'b1;
      end else if (decode) begin
        if (!msg_wr) begin
          // Status access always acks, reply reads wait for data
          wb_ack <= wb_adr || reply_valid;
        end else begin
          case (state)
            ST_CMD: begin
              if (msg.cmd.opcode == OP_WRITE && cmd_ok) begin
                beats_left <= msg.cmd.length;
                word_idx   <= '0;
                state      <= ST_DATA;
                wb_ack     <= 1'b1;
              end else if (msg.cmd.opcode == OP_READ && cmd_ok) begin
                rd_valid <= 1'b1;
              end else if (msg.cmd.opcode == OP_END) begin
                done   <= 1'b1;
                state  <= ST_DONE;
                wb_ack <= 1'b1;
              end else begin
                // Bad opcode or empty burst, word dropped
                error  <= 1'b1;
                wb_ack <= 1'b1;
              end
            end
            ST_DATA: begin
              if (last_word) begin
                wr_valid <= 1'b1;
              end else begin
                word_idx <= word_idx + 1'b1;
                wb_ack   <= 1'b1;
              end
            end
            default: wb_ack <= 1'b1;
          endcase
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (load_word) begin
      wr_data[word_idx*MSG_WIDTH +: MSG_WIDTH] <= msg.raw;
    end
    if (cmd_load) begin
      wr_addr <= msg.cmd.beat_addr;
      rd_addr <= msg.cmd.beat_addr;
      rd_len  <= msg.cmd.length;
    end else if (wr_valid && wr_ready) begin
      wr_addr <= wr_addr + 1'b1;
    end
    if (decode && !wb_we) begin
      wb_dat_o <= wb_adr ? status_word : reply_word;
    end
  end

  ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

// ==== verilog/reply_buffer.sv ====
module reply_buffer #(
  parameter int REPLY_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              read_issued,
  output logic                              slot_free,
  input  logic                              app_rd_data_valid,
  input  logic [bridge_pkg::BEAT_WIDTH-1:0] app_rd_data,
  output logic                              reply_valid,
  output logic [bridge_pkg::MSG_WIDTH-1:0]  reply_word,
  input  logic                              reply_take
);
  import bridge_pkg::*;

  localparam int PTR_WIDTH = $clog2(REPLY_DEPTH);
  localparam int IDX_WIDTH = $clog2(WORDS_PER_BEAT);
  localparam logic [PTR_WIDTH:0] DEPTH_CNT = (PTR_WIDTH + 1)'(REPLY_DEPTH);

  logic [BEAT_WIDTH-1:0] mem [REPLY_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  // Slots held by issued reads, filled or not
  logic [PTR_WIDTH:0]    reserved;
  logic [PTR_WIDTH:0]    filled;
  logic [IDX_WIDTH-1:0]  word_idx;
  logic                  beat_done;

  assign beat_done   = reply_take && (word_idx == IDX_WIDTH'(WORDS_PER_BEAT - 1));
  assign slot_free   = (reserved != DEPTH_CNT);
  assign reply_valid = (filled != '0);
  assign reply_word  = mem[rd_ptr][word_idx*MSG_WIDTH +: MSG_WIDTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      reserved <= '0;
      filled   <= '0;
      word_idx <= '0;
    end else begin
      if (app_rd_data_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Word index wraps to 0 after the last word
      if (reply_take) begin
        word_idx <= word_idx + 1'b1;
      end
      if (beat_done) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({read_issued, beat_done})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: reserved <= reserved;
      endcase
      case ({app_rd_data_valid, beat_done})
        2'b10:   filled <= filled + 1'b1;
        2'b01:   filled <= filled - 1'b1;
        default: filled <= filled;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (app_rd_data_valid) begin
      mem[wr_ptr] <= app_rd_data;
    end
  end

  // Returning beats always land in a slot reserved at issue
  rd_data_reserved: assert property (@(posedge clk) disable iff (!arst_n)
    app_rd_data_valid |-> (reserved > filled));

endmodule
